//--- verilog/weight_loader_settings.svh
`ifndef WEIGHT_LOADER_SETTINGS_SVH
`define WEIGHT_LOADER_SETTINGS_SVH

// bits per weight word on both streams
`define WL_DATA_W 16

// one buffer per enable mask bit
`define WL_NUM_BUF 4

// entries per weight buffer
// the busiest buffer only takes 13 words per kernel
`define WL_BUF_DEPTH 16

// words per 5x5 kernel
// also the number of schedule positions
`define WL_SCHED_LEN 25

`endif

//--- verilog/sched_pkg.sv
`include "weight_loader_settings.svh"

package sched_pkg;

    // schedule position of the current weight word
    // counts 0 .. WL_SCHED_LEN-1 inside one kernel
    typedef logic [$clog2(`WL_SCHED_LEN)-1:0] sched_cnt_t;

    // one bit per weight buffer
    // bit n set means the word goes into buffer n
    typedef logic [`WL_NUM_BUF-1:0] buf_en_t;

endpackage

//--- verilog/stream_pkg.sv
`include "weight_loader_settings.svh"

package stream_pkg;

    // one weight word as it arrives on the load stream
    typedef logic [`WL_DATA_W-1:0] weight_word_t;

    // buffer number carried with each drained word
    typedef logic [$clog2(`WL_NUM_BUF)-1:0] buf_id_t;

    // entry position inside one buffer
    typedef logic [$clog2(`WL_BUF_DEPTH)-1:0] buf_idx_t;

    // one record on the drain stream
    // tagged so the consumer knows where the word sat
    typedef struct packed {
        buf_id_t      buf_id;
        buf_idx_t     idx;
        weight_word_t data;
    } drain_rec_t;

endpackage

//--- verilog/weight_en_decoder.sv
`timescale 1ns/1ps

`include "weight_loader_settings.svh"

module weight_en_decoder (
    input  sched_pkg::sched_cnt_t sched_cnt,
    output sched_pkg::buf_en_t    buf_en
);

    // true and complemented count bits
    logic [4:0] c;
    logic [4:0] cn;

    // product terms, one vector per mask bit
    logic [5:0] p3;
    logic [5:0] p2;
    logic [6:0] p1;
    logic [5:0] p0;

    assign c  = sched_cnt;
    assign cn = ~sched_cnt;

    // bit 3 covers counts 0 4 5 8-11 16 18-20 23 24
    assign p3[0] = c[4]  & cn[3] & c[2]  & cn[1] & cn[0];   // 20
    assign p3[1] = c[4]  & cn[3] & cn[2] & c[1]  & cn[0];   // 18
    assign p3[2] = c[4]  & cn[3] & c[1]  & c[0];            // 19 23
    assign p3[3] = cn[4] & cn[3] & c[2]  & cn[1];           // 4 5
    assign p3[4] = cn[2] & cn[1] & cn[0];                   // 0 8 16 24
    assign p3[5] = cn[4] & c[3]  & cn[2];                   // 8 .. 11

    // bit 2 covers counts 1 5 6 9 11-13 18 20
    assign p2[0] = cn[4] & c[3]  & cn[2] & c[1]  & c[0];    // 11
    assign p2[1] = cn[4] & cn[3] & c[2]  & c[1]  & cn[0];   // 6
    assign p2[2] = c[4]  & cn[3] & c[2]  & cn[1] & cn[0];   // 20
    assign p2[3] = c[4]  & cn[3] & cn[2] & c[1]  & cn[0];   // 18
    assign p2[4] = cn[4] & c[3]  & c[2]  & cn[1];           // 12 13
    assign p2[5] = cn[4] & cn[1] & c[0];                    // 1 5 9 13

    // bit 1 covers counts 2 6 7 11 13-16 21 22
    assign p1[0] = c[4]  & cn[3] & cn[2] & cn[1] & cn[0];   // 16
    assign p1[1] = cn[4] & c[3]  & c[2]  & c[0];            // 13 15
    assign p1[2] = c[4]  & cn[3] & c[2]  & cn[1] & c[0];    // 21
    assign p1[3] = cn[4] & c[3]  & cn[2] & c[1]  & c[0];    // 11
    assign p1[4] = cn[3] & c[2]  & c[1]  & cn[0];           // 6 22
    assign p1[5] = cn[4] & cn[3] & c[1]  & cn[0];           // 2 6
    assign p1[6] = cn[4] & c[2]  & c[1];                    // 6 7 14 15

    // bit 0 covers counts 3 8 9 15-18 22 23
    assign p0[0] = cn[4] & c[3]  & c[2]  & c[1]  & c[0];    // 15
    assign p0[1] = cn[4] & cn[3] & cn[2] & c[1]  & c[0];    // 3
    assign p0[2] = c[4]  & cn[3] & cn[2] & c[1]  & cn[0];   // 18
    assign p0[3] = cn[4] & c[3]  & cn[2] & cn[1];           // 8 9
    assign p0[4] = c[4]  & cn[3] & cn[2] & cn[1];           // 16 17
    assign p0[5] = c[4]  & cn[3] & c[2]  & c[1];            // 22 23

    // sum of products per mask bit
    // counts 25 and up hit no term and give an empty mask
    assign buf_en[3] = |p3;
    assign buf_en[2] = |p2;
    assign buf_en[1] = |p1;
    assign buf_en[0] = |p0;

    // every schedule position must land in at least one buffer
    always_comb begin
        if (int'(sched_cnt) < `WL_SCHED_LEN) begin
            assert (buf_en != '0);
        end
    end

endmodule

//--- verilog/sched_counter.sv
`timescale 1ns/1ps

`include "weight_loader_settings.svh"

module sched_counter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  cnt_step,
    output sched_pkg::sched_cnt_t sched_cnt,
    output logic                  cnt_last
);

    // final schedule position of a kernel
    localparam sched_pkg::sched_cnt_t LAST_POS =
        sched_pkg::sched_cnt_t'(`WL_SCHED_LEN - 1);

    // position steps once per accepted word
    // wraps to 0 after the last word of the kernel
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sched_cnt <= '0;
        end else if (cnt_step) begin
            if (cnt_last) begin
                sched_cnt <= '0;
            end else begin
                sched_cnt <= sched_cnt + 1'b1;
            end
        end
    end

    // marks the 25th word of the kernel
    assign cnt_last = (sched_cnt == LAST_POS);

    // position stays inside the schedule table
    assert property (@(posedge clk) disable iff (reset)
        sched_cnt <= LAST_POS);

endmodule

//--- verilog/load_ctrl_fsm.sv
`timescale 1ns/1ps

module load_ctrl_fsm (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  logic out_ready,
    output logic out_valid,
    input  logic cnt_last,
    input  logic drain_last,
    output logic cnt_step,
    output logic wr_fire,
    output logic rd_fire,
    output logic clear
);

    // LOAD takes words, DRAIN hands out records
    typedef enum logic {
        LOAD  = 1'b0,
        DRAIN = 1'b1
    } state_t;

    state_t state;
    state_t state_nxt;

    // handshakes on both streams
    logic in_accept;
    logic out_accept;

    assign in_accept  = in_valid & in_ready;
    assign out_accept = out_valid & out_ready;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            LOAD: begin
                // 25th word closes the kernel
                if (in_accept && cnt_last) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                // last record leaves, back to loading
                if (out_accept && drain_last) begin
                    state_nxt = LOAD;
                end
            end
            default: begin
                state_nxt = LOAD;
            end
        endcase
    end

    // state and stream flags are registered together
    // flags stay low through reset and follow the state after it
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= LOAD;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            in_ready  <= (state_nxt == LOAD);
            out_valid <= (state_nxt == DRAIN);
        end
    end

    // in_ready is only high in LOAD, out_valid only in DRAIN
    // so the accepts are already qualified by the state
    assign wr_fire  = in_accept;
    assign cnt_step = in_accept;
    assign rd_fire  = out_accept;

    // empties counter and buffers on the same edge that returns to LOAD
    assign clear = out_accept & drain_last;

    // the two streams never run at once
    assert property (@(posedge clk) disable iff (reset)
        !(in_ready && out_valid));

    // closing word of a kernel hands over to the drain on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        (in_accept && cnt_last) |=> (!in_ready && out_valid));

endmodule

//--- verilog/weight_buffer_bank.sv
`timescale 1ns/1ps

`include "weight_loader_settings.svh"

module weight_buffer_bank (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clear,
    input  logic                     wr_fire,
    input  sched_pkg::buf_en_t       buf_en,
    input  stream_pkg::weight_word_t in_data,
    input  logic                     rd_fire,
    output stream_pkg::drain_rec_t   out_rec,
    output logic                     drain_last
);

    localparam int NUM_BUF = `WL_NUM_BUF;
    localparam int DEPTH   = `WL_BUF_DEPTH;

    // fill level needs one bit more than an index to reach DEPTH
    typedef logic [$clog2(DEPTH):0] fill_t;

    // weight storage, one row per buffer
    stream_pkg::weight_word_t mem [NUM_BUF][DEPTH];

    // write pointers double as fill levels
    fill_t wr_ptr [NUM_BUF];

    // drain position, buffer then entry
    stream_pkg::buf_id_t  rd_buf;
    stream_pkg::buf_idx_t rd_idx;

    // buffer the drain actually reads, rd_buf moved past empty buffers
    stream_pkg::buf_id_t cur_buf;

    // a nonempty buffer follows cur_buf
    logic later_nz;

    // current entry is the last one of cur_buf
    logic last_in_buf;

    // append to every enabled buffer
    always_ff @(posedge clk) begin
        for (int n = 0; n < NUM_BUF; n++) begin
            if (wr_fire && buf_en[n]) begin
                mem[n][wr_ptr[n][$clog2(DEPTH)-1:0]] <= in_data;
            end
        end
    end

    // skip empty buffers
    // descending scan leaves the lowest nonempty buffer at or after rd_buf
    always_comb begin
        cur_buf = rd_buf;
        for (int b = NUM_BUF - 1; b >= 0; b--) begin
            if (b >= int'(rd_buf) && wr_ptr[b] != '0) begin
                cur_buf = stream_pkg::buf_id_t'(b);
            end
        end
    end

    // look for work beyond the current buffer
    always_comb begin
        later_nz = 1'b0;
        for (int b = 0; b < NUM_BUF; b++) begin
            if (b > int'(cur_buf) && wr_ptr[b] != '0) begin
                later_nz = 1'b1;
            end
        end
    end

    assign last_in_buf = (fill_t'(rd_idx) + fill_t'(1)) == wr_ptr[cur_buf];
    assign drain_last  = last_in_buf & ~later_nz;

    // record is read straight from storage at the drain position
    always_comb begin
        out_rec.buf_id = cur_buf;
        out_rec.idx    = rd_idx;
        out_rec.data   = mem[cur_buf][rd_idx];
    end

    // pointer updates
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            for (int n = 0; n < NUM_BUF; n++) begin
                wr_ptr[n] <= '0;
            end
            rd_buf <= '0;
            rd_idx <= '0;
        end else begin
            for (int n = 0; n < NUM_BUF; n++) begin
                if (wr_fire && buf_en[n]) begin
                    wr_ptr[n] <= wr_ptr[n] + 1'b1;
                end
            end
            if (rd_fire) begin
                if (last_in_buf) begin
                    // next buffer, may be empty, the scan skips it
                    rd_buf <= cur_buf + 1'b1;
                    rd_idx <= '0;
                end else begin
                    rd_buf <= cur_buf;
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    // no write into a full buffer
    for (genvar n = 0; n < NUM_BUF; n++) begin : g_fill_chk
        assert property (@(posedge clk) disable iff (reset)
            (wr_fire && buf_en[n]) |-> (wr_ptr[n] < fill_t'(DEPTH)));
    end

    // buffers fill only while nothing is being drained
    assert property (@(posedge clk) disable iff (reset)
        !(wr_fire && rd_fire));

endmodule

//--- verilog/weight_loader_top.sv
`timescale 1ns/1ps

module weight_loader_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  stream_pkg::weight_word_t in_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output stream_pkg::drain_rec_t   out_rec
);

    // schedule position and its enable mask
    sched_pkg::sched_cnt_t sched_cnt;
    sched_pkg::buf_en_t    buf_en;

    // controller strobes
    logic cnt_step;
    logic cnt_last;
    logic wr_fire;
    logic rd_fire;
    logic drain_last;
    logic clear;

    // both handshakes, load and drain sequencing
    load_ctrl_fsm u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .cnt_last   (cnt_last),
        .drain_last (drain_last),
        .cnt_step   (cnt_step),
        .wr_fire    (wr_fire),
        .rd_fire    (rd_fire),
        .clear      (clear)
    );

    // word number inside the kernel
    sched_counter u_cnt (
        .clk       (clk),
        .reset     (reset),
        .clear     (clear),
        .cnt_step  (cnt_step),
        .sched_cnt (sched_cnt),
        .cnt_last  (cnt_last)
    );

    // fixed count to mask table
    weight_en_decoder u_dec (
        .sched_cnt (sched_cnt),
        .buf_en    (buf_en)
    );

    // storage and ordered read-out
    weight_buffer_bank u_bank (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .wr_fire    (wr_fire),
        .buf_en     (buf_en),
        .in_data    (in_data),
        .rd_fire    (rd_fire),
        .out_rec    (out_rec),
        .drain_last (drain_last)
    );

endmodule

//--- sim/weight_loader_tb.sv
`timescale 1ns/1ps

`include "weight_loader_settings.svh"

module weight_loader_tb;

    localparam int SCHED_LEN = `WL_SCHED_LEN;
    localparam int NUM_BUF   = `WL_NUM_BUF;
    localparam int WAIT_MAX  = 200;
    localparam int KERNELS   = 3;

    // reference count to mask table
    // bit 3 is the leftmost bit of each hex digit
    localparam logic [0:SCHED_LEN-1][NUM_BUF-1:0] MAP = {
        4'h8, 4'h4, 4'h2, 4'h1, 4'h8,
        4'hC, 4'h6, 4'h2, 4'h9, 4'hD,
        4'h8, 4'hE, 4'h4, 4'h6, 4'h2,
        4'h3, 4'hB, 4'h1, 4'hD, 4'h8,
        4'hC, 4'h2, 4'h3, 4'h9, 4'h8
    };

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    logic                     in_ready;
    stream_pkg::weight_word_t in_data;
    logic                     out_valid;
    logic                     out_ready;
    stream_pkg::drain_rec_t   out_rec;

    integer seed;
    int rec_errors;
    int mask_errors;
    int count_errors;
    int flag_errors;
    int timeout_errors;

    // model buffers filled in schedule order
    stream_pkg::weight_word_t model_mem [NUM_BUF][SCHED_LEN];
    int model_fill [NUM_BUF];

    // buffers each schedule position showed up in as rebuilt from the drain tags
    sched_pkg::buf_en_t seen_mask [SCHED_LEN];

    weight_loader_top UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rec   (out_rec)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_rec(input stream_pkg::drain_rec_t got,
                             input stream_pkg::drain_rec_t exp, input string what);
        if (got !== exp) begin
            rec_errors++;
            $display("CHECK FAILED at %0t: %s: got buf/idx/data %0d/%0d/%h, expected %0d/%0d/%h",
                $time, what, got.buf_id, got.idx, got.data, exp.buf_id, exp.idx, exp.data);
        end
    endtask

    task automatic check_mask(input sched_pkg::buf_en_t got,
                              input sched_pkg::buf_en_t exp, input string what);
        if (got !== exp) begin
            mask_errors++;
            $display("CHECK FAILED at %0t: %s: got mask %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            count_errors++;
            $display("CHECK FAILED at %0t: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("CHECK FAILED at %0t: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // closing summary and then the verdict
    task automatic finish_run();
        int total;
        total = rec_errors + mask_errors + count_errors + flag_errors + timeout_errors;
        $display("errors: record %0d, mask %0d, count %0d, flag %0d, timeout %0d",
            rec_errors, mask_errors, count_errors, flag_errors, timeout_errors);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("TIMEOUT at %0t: %s", $time, what);
    endtask

    // sampled on falling edges where all DUT outputs are settled
    task automatic wait_in_ready(input string what);
        int guard;
        guard = 0;
        @(negedge clk);
        while (!in_ready) begin
            guard++;
            if (guard > WAIT_MAX) begin
                report_timeout(what);
                return;
            end
            @(negedge clk);
        end
    endtask

    // upper bits random
    // low 5 bits carry the schedule position
    function automatic stream_pkg::weight_word_t make_word(input int k);
        int r;
        r = $random(seed);
        return {r[`WL_DATA_W-1:5], 5'(k)};
    endfunction

    // word goes to every buffer named in the table mask
    task automatic model_push(input stream_pkg::weight_word_t word, input int k);
        sched_pkg::buf_en_t m;
        m = MAP[k];
        for (int b = 0; b < NUM_BUF; b++) begin
            if (m[b]) begin
                model_mem[b][model_fill[b]] = word;
                model_fill[b]++;
            end
        end
    endtask

    task automatic load_kernel(input int kern);
        int   k;
        int   guard;
        int   r;
        logic took;
        k     = 0;
        guard = 0;
        took  = 1'b0;
        while (k < SCHED_LEN) begin
            @(posedge clk);
            // data is held until taken, then maybe a gap
            if (!in_valid || took) begin
                r = $random(seed);
                if (r[1:0] == 2'b00) begin
                    in_valid <= 1'b0;
                end else begin
                    in_valid <= 1'b1;
                    in_data  <= make_word(k);
                end
            end
            @(negedge clk);
            check_flag(out_valid, 1'b0, "out_valid while loading");
            took = in_valid && in_ready;
            if (took) begin
                model_push(in_data, k);
                k++;
                guard = 0;
            end else begin
                guard++;
                if (guard > WAIT_MAX) begin
                    report_timeout($sformatf("word %0d of kernel %0d never accepted", k, kern));
                    return;
                end
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drain_kernel(input int kern);
        stream_pkg::drain_rec_t exp_q [$];
        stream_pkg::drain_rec_t exp;
        stream_pkg::drain_rec_t held;
        int   per_buf [NUM_BUF];
        int   n;
        int   guard;
        int   pos;
        int   r;
        logic stalled;
        // buffer 0 first, each buffer in write order
        for (int b = 0; b < NUM_BUF; b++) begin
            per_buf[b] = 0;
            for (int i = 0; i < model_fill[b]; i++) begin
                exp.buf_id = stream_pkg::buf_id_t'(b);
                exp.idx    = stream_pkg::buf_idx_t'(i);
                exp.data   = model_mem[b][i];
                exp_q.push_back(exp);
            end
        end
        for (int k = 0; k < SCHED_LEN; k++) begin
            seen_mask[k] = '0;
        end
        n       = 0;
        guard   = 0;
        stalled = 1'b0;
        while (n < exp_q.size()) begin
            @(posedge clk);
            r = $random(seed);
            out_ready <= (r[1:0] != 2'b00);
            @(negedge clk);
            check_flag(in_ready, 1'b0, "in_ready while draining");
            // a refused record must still be there unchanged
            if (stalled) begin
                check_flag(out_valid, 1'b1, "out_valid dropped while stalled");
                check_rec(out_rec, held, "record changed while stalled");
            end
            stalled = 1'b0;
            if (out_valid && out_ready) begin
                check_rec(out_rec, exp_q[n], $sformatf("kernel %0d record %0d", kern, n));
                pos = int'(out_rec.data[4:0]);
                if (pos < SCHED_LEN) begin
                    seen_mask[pos][out_rec.buf_id] = 1'b1;
                end
                per_buf[out_rec.buf_id]++;
                n++;
                guard = 0;
            end else begin
                if (out_valid) begin
                    held    = out_rec;
                    stalled = 1'b1;
                end
                guard++;
                if (guard > WAIT_MAX) begin
                    report_timeout($sformatf("drain of kernel %0d stopped at record %0d",
                        kern, n));
                    return;
                end
            end
        end
        @(posedge clk);
        out_ready <= 1'b0;
        // the last record must hand control back to loading
        wait_in_ready($sformatf("kernel %0d did not return to load after its drain", kern));
        for (int b = 0; b < NUM_BUF; b++) begin
            check_count(per_buf[b], model_fill[b], $sformatf("records from buffer %0d", b));
            model_fill[b] = 0;
        end
        for (int k = 0; k < SCHED_LEN; k++) begin
            check_mask(seen_mask[k], MAP[k], $sformatf("mask at count %0d", k));
        end
    endtask

    initial begin
        seed           = 32'h79eb_c821;
        rec_errors     = 0;
        mask_errors    = 0;
        count_errors   = 0;
        flag_errors    = 0;
        timeout_errors = 0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;
        for (int b = 0; b < NUM_BUF; b++) begin
            model_fill[b] = 0;
        end
        // reset over two rising edges with both streams quiet
        @(posedge clk);
        @(negedge clk);
        check_flag(in_ready, 1'b0, "in_ready during reset");
        check_flag(out_valid, 1'b0, "out_valid during reset");
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag(in_ready, 1'b0, "in_ready at end of reset");
        check_flag(out_valid, 1'b0, "out_valid at end of reset");
        wait_in_ready("in_ready never rose after reset");
        // back to back kernels also exercise clear
        for (int kern = 0; kern < KERNELS && timeout_errors == 0; kern++) begin
            load_kernel(kern);
            if (timeout_errors == 0) begin
                drain_kernel(kern);
            end
        end
        finish_run();
    end

endmodule

//--- all.f
+incdir+verilog
verilog/sched_pkg.sv
verilog/stream_pkg.sv
verilog/weight_en_decoder.sv
verilog/sched_counter.sv
verilog/load_ctrl_fsm.sv
verilog/weight_buffer_bank.sv
verilog/weight_loader_top.sv
sim/weight_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the weight loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module weight_loader_tb

status=0
./obj_dir/Vweight_loader_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, exit status $status"
    exit 1
fi
